// File: Makefile
# Verilator build and run for the ILI9486 display subsystem

VERILATOR  ?= verilator
TOP        ?= tb_display_top
RTL_TOP    ?= display_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= SIMULATION PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter source/%,$(SOURCES))

clean:
	rm -rf $(BUILD_DIR)

// File: source/display_pkg.sv
package display_pkg;

  // Tile geometry
  localparam int TILE_W    = 32;
  localparam int TILE_H    = 32;
  localparam int PIX_DEPTH = TILE_W * TILE_H;
  localparam int PIX_AW    = 10;

  // Bus word seen as raw bits or as colour bytes
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [7:0] pad;
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
    } col;
  } pixel_word_u;

  // Window on the panel
  localparam logic [15:0] WIN_X0 = 16'd48;
  localparam logic [15:0] WIN_Y0 = 16'd96;
  localparam logic [15:0] WIN_X1 = WIN_X0 + 16'(TILE_W - 1);
  localparam logic [15:0] WIN_Y1 = WIN_Y0 + 16'(TILE_H - 1);

  // ILI9486 commands
  localparam logic [7:0] CMD_CASET = 8'h2A;
  localparam logic [7:0] CMD_PASET = 8'h2B;
  localparam logic [7:0] CMD_RAMWR = 8'h2C;
  localparam int PRE_BYTES = 11;

  // Write strobe shape
  localparam int WR_LOW_CYCLES  = 2;
  localparam int WR_HIGH_CYCLES = 2;
  localparam int PH_W = $clog2(WR_LOW_CYCLES + WR_HIGH_CYCLES);

  // Pixel link credits and FIFO
  localparam int CREDITS  = 4;
  localparam int CREDIT_W = $clog2(CREDITS + 1);
  localparam int FIFO_AW  = $clog2(CREDITS);

  // Panel sequencer states
  localparam int SEQ_W = 3;
  localparam logic [SEQ_W-1:0] SEQ_IDLE = 3'd0;
  localparam logic [SEQ_W-1:0] SEQ_PRE  = 3'd1;
  localparam logic [SEQ_W-1:0] SEQ_HI   = 3'd2;
  localparam logic [SEQ_W-1:0] SEQ_LO   = 3'd3;
  localparam logic [SEQ_W-1:0] SEQ_WAIT = 3'd4;

endpackage

// File: source/display_top.sv
`timescale 1ns/100ps

module display_top
  import wishbone_pkg::*;
  import display_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [WB_ADR_W-1:0]   wb_adr_i,
  input  logic [WB_SEL_W-1:0]   wb_sel_i,
  input  logic [WB_DAT_W-1:0]   wb_dat_i,
  output logic                  wb_ack_o,
  output logic [WB_DAT_W-1:0]   wb_dat_o,
  input  logic                  frame_start_i,
  input  logic [BANK_IDX_W-1:0] frame_bank_i,
  output logic                  busy_o,
  output logic                  lcd_csx_o,
  output logic                  lcd_dcx_o,
  output logic                  lcd_wrx_o,
  output logic [7:0]            lcd_data_o
);

  logic [BANK_IDX_W-1:0] scan_bank;
  logic [PIX_AW-1:0]     scan_addr;
  logic [WB_DAT_W-1:0]   scan_pixel;
  logic                  pix_valid;
  logic                  pix_sof;
  logic [23:0]           pix_rgb;
  logic                  pix_credit;

  ili9486_buffer u_buffer (
    .clk          (clk),
    .rst          (rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o),
    .scan_bank_i  (scan_bank),
    .scan_addr_i  (scan_addr),
    .scan_pixel_o (scan_pixel)
  );

  scanout_reader u_reader (
    .clk           (clk),
    .rst           (rst),
    .frame_start_i (frame_start_i),
    .frame_bank_i  (frame_bank_i),
    .pix_credit_i  (pix_credit),
    .scan_bank_o   (scan_bank),
    .scan_addr_o   (scan_addr),
    .scan_pixel_i  (scan_pixel),
    .pix_valid_o   (pix_valid),
    .pix_sof_o     (pix_sof),
    .pix_rgb_o     (pix_rgb),
    .busy_o        (busy_o)
  );

  ili9486_parallel_if u_panel (
    .clk          (clk),
    .rst          (rst),
    .pix_valid_i  (pix_valid),
    .pix_sof_i    (pix_sof),
    .pix_rgb_i    (pix_rgb),
    .pix_credit_o (pix_credit),
    .lcd_csx_o    (lcd_csx_o),
    .lcd_dcx_o    (lcd_dcx_o),
    .lcd_wrx_o    (lcd_wrx_o),
    .lcd_data_o   (lcd_data_o)
  );

endmodule

// File: source/ili9486_buffer.sv
`timescale 1ns/100ps

module ili9486_buffer
  import wishbone_pkg::*;
  import display_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [WB_ADR_W-1:0]   wb_adr_i,
  input  logic [WB_SEL_W-1:0]   wb_sel_i,
  input  logic [WB_DAT_W-1:0]   wb_dat_i,
  output logic                  wb_ack_o,
  output logic [WB_DAT_W-1:0]   wb_dat_o,
  input  logic [BANK_IDX_W-1:0] scan_bank_i,
  input  logic [PIX_AW-1:0]     scan_addr_i,
  output logic [WB_DAT_W-1:0]   scan_pixel_o
);

  logic [15:0]                   bank_field;
  logic [NUM_BANKS-1:0]          bank_hit;
  logic [PIX_AW-1:0]             pix_idx;
  logic [NUM_BANKS-1:0][2:0]     wren;
  logic [NUM_BANKS-1:0][2:0][7:0] bus_rd;
  logic [NUM_BANKS-1:0][2:0][7:0] scan_rd;
  logic [2:0][7:0]               wr_lane;
  pixel_word_u                   wr_word;
  pixel_word_u                   rd_word;
  pixel_word_u                   scan_word;
  logic [BANK_IDX_W-1:0]         scan_bank_q;
  logic                          idle;
  logic                          accessing;

  assign bank_field = wb_adr_i[WB_ADR_W-1:BANK_LSB];
  assign pix_idx    = wb_adr_i[PIX_AW+1:2];

  // Lane 0 blue, lane 1 green, lane 2 red
  assign wr_word.raw = wb_dat_i;
  assign wr_lane[0]  = wr_word.col.blue;
  assign wr_lane[1]  = wr_word.col.green;
  assign wr_lane[2]  = wr_word.col.red;

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    assign bank_hit[b] = (bank_field == BANK_CODES[b]);

    for (genvar c = 0; c < 3; c++)
    begin : g_colour
      assign wren[b][c] = wb_cyc_i & wb_stb_i & wb_we_i & wb_sel_i[c] & bank_hit[b];

      pixel_ram u_ram (
        .clk      (clk),
        .we_i     (wren[b][c]),
        .a_addr_i (pix_idx),
        .a_data_i (wr_lane[c]),
        .a_data_o (bus_rd[b][c]),
        .b_addr_i (scan_addr_i),
        .b_data_o (scan_rd[b][c])
      );
    end
  end

  // Unknown bank code reads zero
  always_comb
  begin
    rd_word.raw = '0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (bank_hit[b])
      begin
        rd_word.col.blue  = bus_rd[b][0];
        rd_word.col.green = bus_rd[b][1];
        rd_word.col.red   = bus_rd[b][2];
      end
    end
  end

  // Bank register follows the RAM read latency
  always_ff @(posedge clk)
  begin
    scan_bank_q <= scan_bank_i;
  end

  always_comb
  begin
    scan_word.raw = '0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (scan_bank_q == BANK_IDX_W'(b))
      begin
        scan_word.col.blue  = scan_rd[b][0];
        scan_word.col.green = scan_rd[b][1];
        scan_word.col.red   = scan_rd[b][2];
      end
    end
  end

  assign scan_pixel_o = scan_word.raw;

  // Idle/accessing pair, ack two cycles after strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idle      <= 1'b1;
      accessing <= 1'b0;
      wb_ack_o  <= 1'b0;
    end
    else
    begin
      wb_ack_o <= 1'b0;
      if (idle)
      begin
        // Strobe still high in the ack cycle belongs to the finished access
        if (wb_cyc_i && wb_stb_i && !wb_ack_o)
        begin
          idle      <= 1'b0;
          accessing <= 1'b1;
        end
      end
      else if (accessing)
      begin
        accessing <= 1'b0;
        idle      <= 1'b1;
        wb_ack_o  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accessing)
    begin
      wb_dat_o <= rd_word.raw;
    end
  end

endmodule

// File: source/ili9486_parallel_if.sv
`timescale 1ns/100ps

module ili9486_parallel_if
  import display_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        pix_valid_i,
  input  logic        pix_sof_i,
  input  logic [23:0] pix_rgb_i,
  output logic        pix_credit_o,
  output logic        lcd_csx_o,
  output logic        lcd_dcx_o,
  output logic        lcd_wrx_o,
  output logic [7:0]  lcd_data_o
);

  logic [24:0]         fifo_mem [CREDITS];
  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [CREDIT_W-1:0] fifo_cnt;
  logic [24:0]         fifo_head;
  logic                fifo_empty;
  logic                pop;
  logic [SEQ_W-1:0]    state;
  logic                active;
  logic [PH_W-1:0]     phase;
  logic                byte_end;
  logic [3:0]          pre_idx;
  logic [PIX_AW-1:0]   pix_cnt;
  logic                last_pix;
  logic [23:0]         pix_q;
  logic [15:0]         pix_q565;
  logic [15:0]         head565;
  logic [8:0]          pre_word;
  logic                launch;
  logic [8:0]          launch_word;

  function automatic logic [15:0] to_rgb565(input logic [23:0] rgb);
    return {rgb[23:19], rgb[15:10], rgb[7:3]};
  endfunction

  assign fifo_head  = fifo_mem[rd_ptr];
  assign fifo_empty = (fifo_cnt == '0);
  assign byte_end   = active && (phase == PH_W'(WR_LOW_CYCLES + WR_HIGH_CYCLES - 1));
  assign last_pix   = (pix_cnt == PIX_AW'(PIX_DEPTH - 1));
  assign pix_q565   = to_rgb565(pix_q);
  assign head565    = to_rgb565(fifo_head[23:0]);

  // Credit link guarantees room
  always_ff @(posedge clk)
  begin
    if (pix_valid_i)
    begin
      fifo_mem[wr_ptr] <= {pix_sof_i, pix_rgb_i};
    end
    if (pop)
    begin
      pix_q <= fifo_head[23:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end
    else
    begin
      wr_ptr   <= wr_ptr + FIFO_AW'(pix_valid_i);
      rd_ptr   <= rd_ptr + FIFO_AW'(pop);
      fifo_cnt <= fifo_cnt + CREDIT_W'(pix_valid_i) - CREDIT_W'(pop);
    end
  end

  // {dc, byte} of the window preamble
  always_comb
  begin
    case (pre_idx)
      4'd0:    pre_word = {1'b0, CMD_CASET};
      4'd1:    pre_word = {1'b1, WIN_X0[15:8]};
      4'd2:    pre_word = {1'b1, WIN_X0[7:0]};
      4'd3:    pre_word = {1'b1, WIN_X1[15:8]};
      4'd4:    pre_word = {1'b1, WIN_X1[7:0]};
      4'd5:    pre_word = {1'b0, CMD_PASET};
      4'd6:    pre_word = {1'b1, WIN_Y0[15:8]};
      4'd7:    pre_word = {1'b1, WIN_Y0[7:0]};
      4'd8:    pre_word = {1'b1, WIN_Y1[15:8]};
      4'd9:    pre_word = {1'b1, WIN_Y1[7:0]};
      default: pre_word = {1'b0, CMD_RAMWR};
    endcase
  end

  always_comb
  begin
    pop         = 1'b0;
    launch      = 1'b0;
    launch_word = pre_word;
    case (state)
      SEQ_IDLE:
      begin
        // Stray pixels ahead of a SOF are dropped
        pop    = !fifo_empty;
        launch = !fifo_empty && fifo_head[24];
      end
      SEQ_PRE:
      begin
        launch = byte_end;
        if (pre_idx == 4'(PRE_BYTES))
        begin
          launch_word = {1'b1, pix_q565[15:8]};
        end
      end
      SEQ_HI:
      begin
        launch      = byte_end;
        launch_word = {1'b1, pix_q565[7:0]};
      end
      SEQ_LO, SEQ_WAIT:
      begin
        pop         = !fifo_empty && (state == SEQ_WAIT || (byte_end && !last_pix));
        launch      = pop;
        launch_word = {1'b1, head565[15:8]};
      end
      default:
      begin
        pop = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= SEQ_IDLE;
      active       <= 1'b0;
      phase        <= '0;
      pre_idx      <= '0;
      pix_cnt      <= '0;
      pix_credit_o <= 1'b0;
      lcd_csx_o    <= 1'b1;
      lcd_dcx_o    <= 1'b1;
      lcd_wrx_o    <= 1'b1;
      lcd_data_o   <= '0;
    end
    else
    begin
      pix_credit_o <= pop;
      if (active)
      begin
        phase <= phase + 1'b1;
        if (phase == PH_W'(WR_LOW_CYCLES - 1))
        begin
          lcd_wrx_o <= 1'b1;
        end
      end
      if (byte_end)
      begin
        active <= 1'b0;
      end
      if (launch)
      begin
        lcd_data_o <= launch_word[7:0];
        lcd_dcx_o  <= launch_word[8];
        lcd_wrx_o  <= 1'b0;
        active     <= 1'b1;
        phase      <= '0;
      end

      case (state)
        SEQ_IDLE:
        begin
          if (launch)
          begin
            lcd_csx_o <= 1'b0;
            pre_idx   <= 4'd1;
            pix_cnt   <= '0;
            state     <= SEQ_PRE;
          end
        end
        SEQ_PRE:
        begin
          if (byte_end && pre_idx == 4'(PRE_BYTES))
          begin
            pre_idx <= '0;
            state   <= SEQ_HI;
          end
          else if (byte_end)
          begin
            pre_idx <= pre_idx + 1'b1;
          end
        end
        SEQ_HI:
        begin
          if (byte_end)
          begin
            state <= SEQ_LO;
          end
        end
        SEQ_LO, SEQ_WAIT:
        begin
          if (pop)
          begin
            pix_cnt <= pix_cnt + 1'b1;
            state   <= SEQ_HI;
          end
          else if (byte_end && last_pix)
          begin
            lcd_csx_o <= 1'b1;
            state     <= SEQ_IDLE;
          end
          else if (byte_end)
          begin
            state <= SEQ_WAIT;
          end
        end
        default:
        begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

// File: source/pixel_ram.sv
`timescale 1ns/100ps

module pixel_ram
  import display_pkg::*;
(
  input  logic              clk,
  input  logic              we_i,
  input  logic [PIX_AW-1:0] a_addr_i,
  input  logic [7:0]        a_data_i,
  output logic [7:0]        a_data_o,
  input  logic [PIX_AW-1:0] b_addr_i,
  output logic [7:0]        b_data_o
);

  logic [7:0] mem [PIX_DEPTH];

  // Bus port, read returns the old contents
  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      mem[a_addr_i] <= a_data_i;
    end
    a_data_o <= mem[a_addr_i];
  end

  // Scan-out port
  always_ff @(posedge clk)
  begin
    b_data_o <= mem[b_addr_i];
  end

endmodule

// File: source/scanout_reader.sv
`timescale 1ns/100ps

module scanout_reader
  import wishbone_pkg::*;
  import display_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  frame_start_i,
  input  logic [BANK_IDX_W-1:0] frame_bank_i,
  input  logic                  pix_credit_i,
  output logic [BANK_IDX_W-1:0] scan_bank_o,
  output logic [PIX_AW-1:0]     scan_addr_o,
  input  logic [WB_DAT_W-1:0]   scan_pixel_i,
  output logic                  pix_valid_o,
  output logic                  pix_sof_o,
  output logic [23:0]           pix_rgb_o,
  output logic                  busy_o
);

  logic                issuing;
  logic                first_q;
  logic [CREDIT_W-1:0] credits;
  logic                start;
  logic                issue;
  logic                issue_last;
  logic                rd_last_q;
  pixel_word_u         scan_word;

  assign start      = frame_start_i && !busy_o;
  assign issue      = issuing && (credits != '0);
  assign issue_last = issue && (scan_addr_o == PIX_AW'(PIX_DEPTH - 1));

  // One credit per read, one back per FIFO pop
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credits <= CREDIT_W'(CREDITS);
    end
    else
    begin
      credits <= credits - CREDIT_W'(issue) + CREDIT_W'(pix_credit_i);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_o      <= 1'b0;
      issuing     <= 1'b0;
      first_q     <= 1'b0;
      pix_valid_o <= 1'b0;
      pix_sof_o   <= 1'b0;
      rd_last_q   <= 1'b0;
      scan_addr_o <= '0;
      scan_bank_o <= '0;
    end
    else
    begin
      // Flags follow the RAM read by one cycle
      pix_valid_o <= issue;
      pix_sof_o   <= issue && first_q;
      rd_last_q   <= issue_last;

      if (start)
      begin
        busy_o      <= 1'b1;
        issuing     <= 1'b1;
        first_q     <= 1'b1;
        scan_addr_o <= '0;
        scan_bank_o <= frame_bank_i;
      end
      if (issue)
      begin
        first_q     <= 1'b0;
        scan_addr_o <= scan_addr_o + 1'b1;
      end
      if (issue_last)
      begin
        issuing <= 1'b0;
      end
      if (rd_last_q)
      begin
        busy_o <= 1'b0;
      end
    end
  end

  assign scan_word.raw = scan_pixel_i;
  assign pix_rgb_o = {scan_word.col.red, scan_word.col.green, scan_word.col.blue};

endmodule

// File: source/wishbone_pkg.sv
package wishbone_pkg;

  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = 4;

  // Bank codes carried in wb_adr_i[31:16]
  localparam logic [15:0] BANK0_SEL = 16'h0000;
  localparam logic [15:0] BANK1_SEL = 16'h0001;
  localparam logic [15:0] BANK2_SEL = 16'h0010;

  localparam int NUM_BANKS  = 3;
  localparam int BANK_IDX_W = 2;

  // First address bit of the bank field
  localparam int BANK_LSB = 16;

  // Indexed by bank number
  localparam logic [NUM_BANKS-1:0][15:0] BANK_CODES = {
    BANK2_SEL,
    BANK1_SEL,
    BANK0_SEL
  };

endpackage

// File: src.f
source/wishbone_pkg.sv
source/display_pkg.sv
source/pixel_ram.sv
source/ili9486_buffer.sv
source/scanout_reader.sv
source/ili9486_parallel_if.sv
source/display_top.sv
verification/tb_display_top.sv

// File: verification/tb_display_top.sv
`timescale 1ns/100ps

module tb_display_top
  import wishbone_pkg::*;
  import display_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int PRE_LEN     = 11;
  localparam int FRAME_BYTES = PRE_LEN + 2 * PIX_DEPTH;
  // Bus tests take about five cycles per access
  localparam int BUS_CYCLES  = (2 * NUM_BANKS * PIX_DEPTH + 400) * 5;
  localparam int FRAME_CYCLES = 3 * FRAME_BYTES * (WR_LOW_CYCLES + WR_HIGH_CYCLES);
  localparam int WATCHDOG_CYCLES = 2 * (BUS_CYCLES + FRAME_CYCLES) + 1000;

  logic                  clk;
  logic                  rst;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic                  wb_we_i;
  logic [WB_ADR_W-1:0]   wb_adr_i;
  logic [WB_SEL_W-1:0]   wb_sel_i;
  logic [WB_DAT_W-1:0]   wb_dat_i;
  logic                  wb_ack_o;
  logic [WB_DAT_W-1:0]   wb_dat_o;
  logic                  frame_start_i;
  logic [BANK_IDX_W-1:0] frame_bank_i;
  logic                  busy_o;
  logic                  lcd_csx_o;
  logic                  lcd_dcx_o;
  logic                  lcd_wrx_o;
  logic [7:0]            lcd_data_o;

  logic [23:0] model [NUM_BANKS][PIX_DEPTH];
  logic [8:0]  lcd_bytes [$];
  logic        wrx_prev;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;

  display_top UUT (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_o      (wb_ack_o),
    .wb_dat_o      (wb_dat_o),
    .frame_start_i (frame_start_i),
    .frame_bank_i  (frame_bank_i),
    .busy_o        (busy_o),
    .lcd_csx_o     (lcd_csx_o),
    .lcd_dcx_o     (lcd_dcx_o),
    .lcd_wrx_o     (lcd_wrx_o),
    .lcd_data_o    (lcd_data_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Bank code in the upper half, pixel index in bits 11 to 2
  function automatic logic [31:0] bus_addr(input logic [15:0] code, input int idx);
    logic [PIX_AW-1:0] pix;
    pix = idx[PIX_AW-1:0];
    return {code, 4'h0, pix, 2'b00};
  endfunction

  function automatic logic [15:0] rgb_to_565(input logic [23:0] rgb);
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    red   = rgb[23:16];
    green = rgb[15:8];
    blue  = rgb[7:0];
    return {red[7:3], green[7:2], blue[7:3]};
  endfunction

  // {dc, byte} expected at position n of a frame
  function automatic logic [8:0] expected_byte(input int bank, input int n);
    logic [15:0] x1;
    logic [15:0] y1;
    logic [15:0] c565;
    logic [8:0]  result;
    x1 = WIN_X0 + 16'(TILE_W - 1);
    y1 = WIN_Y0 + 16'(TILE_H - 1);
    case (n)
      0:  result = {1'b0, CMD_CASET};
      1:  result = {1'b1, WIN_X0[15:8]};
      2:  result = {1'b1, WIN_X0[7:0]};
      3:  result = {1'b1, x1[15:8]};
      4:  result = {1'b1, x1[7:0]};
      5:  result = {1'b0, CMD_PASET};
      6:  result = {1'b1, WIN_Y0[15:8]};
      7:  result = {1'b1, WIN_Y0[7:0]};
      8:  result = {1'b1, y1[15:8]};
      9:  result = {1'b1, y1[7:0]};
      10: result = {1'b0, CMD_RAMWR};
      default:
      begin
        c565 = rgb_to_565(model[bank][(n - PRE_LEN) / 2]);
        result = ((n - PRE_LEN) % 2 == 0) ? {1'b1, c565[15:8]} : {1'b1, c565[7:0]};
      end
    endcase
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      $display("error %s expected %h got %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    if (errors == err_mark)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  // Strobe stays up through the ack cycle, then drops
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat, output logic [31:0] rdata);
    int waited;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_sel_i = sel;
    wb_dat_i = dat;
    waited   = 0;
    do
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    while (!wb_ack_o && waited < 16);
    assert (wb_ack_o)
    else
    begin
      $display("no ack for the bus access to address %h", adr);
      errors++;
    end
    check_value("wb_ack_o cycles after strobe", 32'd2, 32'(waited));
    rdata = wb_dat_o;
    @(posedge clk);
    #1;
    check_value("wb_ack_o", 32'd0, 32'(wb_ack_o));
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge clk);
    #1;
    check_value("wb_ack_o", 32'd0, 32'(wb_ack_o));
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [3:0] sel, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, sel, dat, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 4'hF, 32'd0, dat);
  endtask

  task automatic read_and_compare(input int bank, input int idx);
    logic [31:0] rd;
    wb_read(bus_addr(BANK_CODES[bank], idx), rd);
    check_value("wb_dat_o", {8'h00, model[bank][idx]}, rd);
  endtask

  task automatic pulse_start(input int bank);
    @(posedge clk);
    #1;
    frame_start_i = 1'b1;
    frame_bank_i  = BANK_IDX_W'(bank);
    @(posedge clk);
    #1;
    frame_start_i = 1'b0;
  endtask

  task automatic wait_frame_end();
    do @(negedge clk); while (lcd_csx_o);
    do @(negedge clk); while (!lcd_csx_o);
  endtask

  task automatic check_frame(input int bank, input int base);
    int err_mark;
    err_mark = errors;
    for (int n = 0; n < FRAME_BYTES; n++)
    begin
      if (base + n < lcd_bytes.size() && errors - err_mark < 8)
      begin
        check_value("{lcd_dcx_o, lcd_data_o}", 32'(expected_byte(bank, n)),
                    32'(lcd_bytes[base + n]));
      end
    end
  endtask

  task automatic test_full_words();
    logic [31:0] data;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      for (int i = 0; i < PIX_DEPTH; i++)
      begin
        data = next_random();
        wb_write(bus_addr(BANK_CODES[b], i), 4'hF, data);
        model[b][i] = data[23:0];
      end
    end
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      for (int i = 0; i < PIX_DEPTH; i++)
      begin
        read_and_compare(b, i);
      end
    end
  endtask

  task automatic test_byte_lanes();
    logic [31:0] data;
    logic [31:0] rd;
    logic [15:0] bad_codes [2];
    int          idx;
    bad_codes[0] = 16'h0002;
    bad_codes[1] = 16'h0100;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        data = next_random();
        idx  = int'(data[PIX_AW-1:0]);
        for (int lane = 0; lane < 3; lane++)
        begin
          data = next_random();
          wb_write(bus_addr(BANK_CODES[b], idx), 4'(1 << lane), data);
          model[b][idx][lane*8 +: 8] = data[lane*8 +: 8];
          read_and_compare(b, idx);
        end
        // Lane 3 has no colour behind it
        wb_write(bus_addr(BANK_CODES[b], idx), 4'b1000, next_random());
        read_and_compare(b, idx);
      end
    end
    for (int c = 0; c < 2; c++)
    begin
      data = next_random();
      idx  = int'(data[PIX_AW-1:0]);
      wb_write(bus_addr(bad_codes[c], idx), 4'hF, next_random());
      wb_read(bus_addr(bad_codes[c], idx), rd);
      check_value("wb_dat_o", 32'd0, rd);
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        read_and_compare(b, idx);
      end
    end
  endtask

  task automatic test_ack_timing();
    logic [31:0] data;
    wb_cyc_i = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      #1;
      check_value("wb_ack_o", 32'd0, 32'(wb_ack_o));
    end
    wb_cyc_i = 1'b0;
    data = next_random();
    wb_write(bus_addr(BANK_CODES[1], 5), 4'hF, data);
    model[1][5] = data[23:0];
    read_and_compare(1, 5);
    read_and_compare(0, 5);
  endtask

  // Panel bus and Wishbone monitor, sampled away from the clock edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      assert (!wb_ack_o || (wb_cyc_i && wb_stb_i))
      else
      begin
        $display("wb_ack_o was high without an active strobe at %0t", $time);
        errors++;
      end
      assert (!(wrx_prev && !lcd_wrx_o && lcd_csx_o))
      else
      begin
        $display("lcd_wrx_o fell while lcd_csx_o was high at %0t", $time);
        errors++;
      end
      if (!wrx_prev && lcd_wrx_o)
      begin
        lcd_bytes.push_back({lcd_dcx_o, lcd_data_o});
      end
    end
    wrx_prev = lcd_wrx_o;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    int err_mark;
    clk           = 1'b0;
    rst           = 1'b1;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_sel_i      = '0;
    wb_dat_i      = '0;
    frame_start_i = 1'b0;
    frame_bank_i  = '0;
    wrx_prev      = 1'b1;
    rng_state     = 32'hcdd1c180;
    errors        = 0;
    checks        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    err_mark = errors;
    check_value("lcd_csx_o", 32'd1, 32'(lcd_csx_o));
    check_value("lcd_wrx_o", 32'd1, 32'(lcd_wrx_o));
    check_value("lcd_dcx_o", 32'd1, 32'(lcd_dcx_o));
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("wb_ack_o", 32'd0, 32'(wb_ack_o));
    report_test("reset state", err_mark);

    err_mark = errors;
    test_full_words();
    report_test("full word write and read back", err_mark);

    err_mark = errors;
    test_byte_lanes();
    report_test("byte lanes and unknown banks", err_mark);

    err_mark = errors;
    test_ack_timing();
    report_test("ack timing", err_mark);

    err_mark = errors;
    lcd_bytes.delete();
    pulse_start(1);
    wait_frame_end();
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("lcd byte count", 32'(FRAME_BYTES), 32'(lcd_bytes.size()));
    check_frame(1, 0);
    report_test("frame from bank 1", err_mark);

    err_mark = errors;
    lcd_bytes.delete();
    pulse_start(0);
    repeat (20) @(negedge clk);
    check_value("busy_o", 32'd1, 32'(busy_o));
    // Reader is busy, so this start must be dropped
    pulse_start(1);
    do @(negedge clk); while (busy_o);
    pulse_start(2);
    wait_frame_end();
    wait_frame_end();
    repeat (100) @(negedge clk);
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("lcd byte count", 32'(2 * FRAME_BYTES), 32'(lcd_bytes.size()));
    check_frame(0, 0);
    check_frame(2, FRAME_BYTES);
    report_test("back-to-back frames from banks 0 and 2", err_mark);

    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
